//--- design/xbar_macros.svh
`ifndef XBAR_MACROS_SVH
`define XBAR_MACROS_SVH

// sizing of the distribution fabric
// the tree code assumes XBAR_PORTS is a power of two
// and XBAR_DEPTH is log2 of it

// bits in one lane word
`define XBAR_DATA_W 32

// source lanes, and also destination lanes
`define XBAR_PORTS 8

// binary tree levels on each side of the crossbar
// fanout takes XBAR_DEPTH enabled cycles, the mux tree the same
`define XBAR_DEPTH 3

// end to end latency through the core, in enabled cycles
// xbar_core is fanout depth plus mux depth
`define XBAR_LATENCY (2*`XBAR_DEPTH)

`endif

//--- design/xbar_lane_pkg.sv
`default_nettype none

`include "xbar_macros.svh"

// types carried on the streaming lanes
package xbar_lane_pkg;

	// one word on one lane
	typedef logic [`XBAR_DATA_W-1:0] lane_data_t;

	// one valid bit per lane, bit i belongs to lane i
	typedef logic [`XBAR_PORTS-1:0] lane_valid_t;

	// lane words travel as packed arrays of lane_data_t
	// indexed by lane number, [`XBAR_PORTS-1:0]
	// so lane 0 sits in the low bits of the flattened bus
	// and the same layout holds for sources and destinations
	// no payload type carries its own valid bit
	// so valid and data stay in separate registers
	// in every tree stage

endpackage

`default_nettype wire

//--- design/xbar_route_pkg.sv
`default_nettype none

`include "xbar_macros.svh"

// routing and configuration types
package xbar_route_pkg;

	// a source or destination number
	typedef logic [`XBAR_DEPTH-1:0] port_idx_t;

	// configuration opcodes, applied at the next clock edge
	typedef enum logic [1:0]
	{
		CFG_NOP       = 2'd0, // no change
		CFG_SET       = 2'd1, // dest takes src, marked routed
		CFG_CLEAR     = 2'd2, // dest unrouted
		CFG_CLEAR_ALL = 2'd3  // every dest unrouted
	} cfg_op_e;

	// one-hot command matrix
	// bit s*`XBAR_PORTS + d set when destination d takes source s
	// grouped by source so each fanout tree gets a contiguous slice
	// a destination column has at most one bit set
	// a source row may have several, which is broadcast
	typedef logic [`XBAR_PORTS*`XBAR_PORTS-1:0] route_cmd_t;

endpackage

`default_nettype wire

//--- design/xbar_fanout_tree.sv
`timescale 1ns/1ns
`default_nettype none

`include "xbar_macros.svh"

// pipelined 1-to-N fanout of one source word
// nodes numbered as a heap: root 1 is the input, children of n are 2n and 2n+1
// leaves sit at nodes `XBAR_PORTS .. 2*`XBAR_PORTS-1, leaf d is node `XBAR_PORTS+d
module xbar_fanout_tree
(
	input  logic                                         CLK,
	input  logic                                         i_arst_n,
	input  logic                                         i_en,
	input  logic                                         i_valid,
	input  xbar_lane_pkg::lane_data_t                    i_data,
	input  logic [`XBAR_PORTS-1:0]                       i_cmd,   // bit d for destination d
	output xbar_lane_pkg::lane_valid_t                   o_valid, // one per leaf
	output xbar_lane_pkg::lane_data_t [`XBAR_PORTS-1:0]  o_data,
	output logic [`XBAR_PORTS-1:0]                       o_cmd    // leaf d keeps bit d
);
	import xbar_lane_pkg::*;

	localparam int NODES = 2*`XBAR_PORTS;

	lane_data_t              node_data  [2:NODES-1]; // every node below the root is a register
	logic                    node_valid [2:NODES-1];

	// command per level
	// at level l node k owns slice k*(PORTS>>l) of this vector, so halving the slice
	// leaves every bit where it was and each level only re-registers it
	logic [`XBAR_PORTS-1:0]  lvl_cmd [1:`XBAR_DEPTH];

	always_ff @(posedge CLK or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int n = 2; n < NODES; n++)
			begin
				node_data[n]  <= '0;
				node_valid[n] <= 1'b0;
			end
			for (int l = 1; l <= `XBAR_DEPTH; l++)
				lvl_cmd[l] <= '0;
		end
		else if (i_en)
		begin
			for (int n = 2; n < 4; n++) // first level copies the input twice
			begin
				node_data[n]  <= i_data;
				node_valid[n] <= i_valid;
			end
			for (int n = 4; n < NODES; n++)
			begin
				node_data[n]  <= node_data[n/2];
				node_valid[n] <= node_valid[n/2];
			end
			lvl_cmd[1] <= i_cmd;
			for (int l = 2; l <= `XBAR_DEPTH; l++)
				lvl_cmd[l] <= lvl_cmd[l-1];
		end
	end

	always_comb
	begin
		for (int d = 0; d < `XBAR_PORTS; d++)
		begin
			o_data[d]  = node_data[`XBAR_PORTS+d];
			o_valid[d] = node_valid[`XBAR_PORTS+d];
		end
	end

	assign o_cmd = lvl_cmd[`XBAR_DEPTH];

endmodule

`default_nettype wire

//--- design/xbar_mux_tree.sv
`timescale 1ns/1ns
`default_nettype none

`include "xbar_macros.svh"

// pipelined N-to-1 mux for one destination
// heap numbering again: node 1 is the root register, children of n are 2n and 2n+1
// nodes PORTS..2*PORTS-1 are the inputs themselves, so only 1..PORTS-1 hold state
module xbar_mux_tree
(
	input  logic                                         CLK,
	input  logic                                         i_arst_n,
	input  logic                                         i_en,
	input  xbar_lane_pkg::lane_valid_t                   i_valid,
	input  xbar_lane_pkg::lane_data_t [`XBAR_PORTS-1:0]  i_data,
	input  logic [`XBAR_PORTS-1:0]                       i_cmd,   // one-hot or zero
	output logic                                         o_valid,
	output xbar_lane_pkg::lane_data_t                    o_data
);
	import xbar_lane_pkg::*;

	localparam int HALF = `XBAR_PORTS/2; // nodes HALF..PORTS-1 read the inputs

	lane_data_t  node_data  [1:`XBAR_PORTS-1];
	logic        node_valid [1:`XBAR_PORTS-1];
	logic        node_cmd   [1:`XBAR_PORTS-1]; // some input below this node is selected

	always_ff @(posedge CLK or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int n = 1; n < `XBAR_PORTS; n++)
			begin
				node_data[n]  <= '0;
				node_valid[n] <= 1'b0;
				node_cmd[n]   <= 1'b0;
			end
		end
		else if (i_en)
		begin
			// bottom level, pairs of inputs
			for (int n = HALF; n < `XBAR_PORTS; n++)
			begin
				node_cmd[n]   <= i_cmd[2*n-`XBAR_PORTS] | i_cmd[2*n-`XBAR_PORTS+1];
				node_valid[n] <= i_cmd[2*n-`XBAR_PORTS] ? i_valid[2*n-`XBAR_PORTS]
				                                        : i_valid[2*n-`XBAR_PORTS+1];
				node_data[n]  <= i_cmd[2*n-`XBAR_PORTS] ? i_data[2*n-`XBAR_PORTS]
				                                        : i_data[2*n-`XBAR_PORTS+1];
			end
			// upper levels merge registered pairs
			for (int n = 1; n < HALF; n++)
			begin
				node_cmd[n]   <= node_cmd[2*n] | node_cmd[2*n+1];
				node_valid[n] <= node_cmd[2*n] ? node_valid[2*n] : node_valid[2*n+1];
				node_data[n]  <= node_cmd[2*n] ? node_data[2*n] : node_data[2*n+1];
			end
		end
	end

	// with no command bit the right side falls through, so it must not count as valid
	assign o_valid = node_valid[1] & node_cmd[1];
	assign o_data  = node_data[1];

endmodule

`default_nettype wire

//--- design/xbar_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "xbar_macros.svh"

// one-hot pipelined crossbar
// fanout tree per source, mux tree per destination
module xbar_core
(
	input  logic                                         CLK,
	input  logic                                         i_arst_n,
	input  logic                                         i_en,
	input  xbar_lane_pkg::lane_valid_t                   i_valid,
	input  xbar_lane_pkg::lane_data_t [`XBAR_PORTS-1:0]  i_data,
	input  xbar_route_pkg::route_cmd_t                   i_cmd,   // grouped by source
	output xbar_lane_pkg::lane_valid_t                   o_valid,
	output xbar_lane_pkg::lane_data_t [`XBAR_PORTS-1:0]  o_data
);
	import xbar_lane_pkg::*;

	lane_data_t [`XBAR_PORTS-1:0]  fan_data  [`XBAR_PORTS]; // [src][dest]
	lane_valid_t                   fan_valid [`XBAR_PORTS];
	logic [`XBAR_PORTS-1:0]        fan_cmd   [`XBAR_PORTS];

	lane_data_t [`XBAR_PORTS-1:0]  mux_data  [`XBAR_PORTS]; // [dest][src]
	lane_valid_t                   mux_valid [`XBAR_PORTS];
	logic [`XBAR_PORTS-1:0]        mux_cmd   [`XBAR_PORTS];

	for (genvar s = 0; s < `XBAR_PORTS; s++)
	begin : g_src
		xbar_fanout_tree fanout
		(
			.CLK      (CLK),
			.i_arst_n (i_arst_n),
			.i_en     (i_en),
			.i_valid  (i_valid[s]),
			.i_data   (i_data[s]),
			.i_cmd    (i_cmd[s*`XBAR_PORTS +: `XBAR_PORTS]),
			.o_valid  (fan_valid[s]),
			.o_data   (fan_data[s]),
			.o_cmd    (fan_cmd[s])
		);
	end

	// leaf d of every source goes to mux tree d
	always_comb
	begin
		for (int d = 0; d < `XBAR_PORTS; d++)
		begin
			for (int s = 0; s < `XBAR_PORTS; s++)
			begin
				mux_data[d][s]  = fan_data[s][d];
				mux_valid[d][s] = fan_valid[s][d];
				mux_cmd[d][s]   = fan_cmd[s][d];
			end
		end
	end

	for (genvar d = 0; d < `XBAR_PORTS; d++)
	begin : g_dst
		xbar_mux_tree mux
		(
			.CLK      (CLK),
			.i_arst_n (i_arst_n),
			.i_en     (i_en),
			.i_valid  (mux_valid[d]),
			.i_data   (mux_data[d]),
			.i_cmd    (mux_cmd[d]),
			.o_valid  (o_valid[d]),
			.o_data   (o_data[d])
		);
	end

endmodule

`default_nettype wire

//--- design/xbar_route_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "xbar_macros.svh"

// per-destination route register, decoded to the one-hot command matrix
module xbar_route_table
(
	input  logic                        CLK,
	input  logic                        i_arst_n,
	input  xbar_route_pkg::cfg_op_e     i_cfg_op,
	input  xbar_route_pkg::port_idx_t   i_cfg_dest,
	input  xbar_route_pkg::port_idx_t   i_cfg_src,
	output xbar_route_pkg::route_cmd_t  o_cmd
);
	import xbar_route_pkg::*;

	port_idx_t               src_q [`XBAR_PORTS]; // source per destination
	logic [`XBAR_PORTS-1:0]  routed_q;            // destination has a source

	always_ff @(posedge CLK or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			routed_q <= '0;
			for (int d = 0; d < `XBAR_PORTS; d++)
				src_q[d] <= '0;
		end
		else
		begin
			case (i_cfg_op)
				CFG_SET:
				begin
					src_q[i_cfg_dest]    <= i_cfg_src;
					routed_q[i_cfg_dest] <= 1'b1;
				end
				CFG_CLEAR:     routed_q[i_cfg_dest] <= 1'b0;
				CFG_CLEAR_ALL: routed_q <= '0;
				default:       ; // CFG_NOP
			endcase
		end
	end

	// one bit per column at most, since each dest stores a single source
	always_comb
	begin
		for (int s = 0; s < `XBAR_PORTS; s++)
		begin
			for (int d = 0; d < `XBAR_PORTS; d++)
				o_cmd[s*`XBAR_PORTS+d] = routed_q[d] && (src_q[d] == port_idx_t'(s));
		end
	end

endmodule

`default_nettype wire

//--- design/xbar_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "xbar_macros.svh"

// distribution fabric top level
// route changes land at the next edge, data takes 6 enabled cycles
module xbar_top
(
	input  logic                                         CLK,
	input  logic                                         i_arst_n,
	input  logic                                         i_en,       // stalls every tree register
	input  xbar_lane_pkg::lane_valid_t                   i_valid,
	input  xbar_lane_pkg::lane_data_t [`XBAR_PORTS-1:0]  i_data,
	input  xbar_route_pkg::cfg_op_e                      i_cfg_op,
	input  xbar_route_pkg::port_idx_t                    i_cfg_dest,
	input  xbar_route_pkg::port_idx_t                    i_cfg_src,
	output xbar_lane_pkg::lane_valid_t                   o_valid,
	output xbar_lane_pkg::lane_data_t [`XBAR_PORTS-1:0]  o_data
);
	import xbar_route_pkg::*;

	route_cmd_t route_cmd; // sampled by the fanout trees with the source words

	xbar_route_table route_table
	(
		.CLK        (CLK),
		.i_arst_n   (i_arst_n),
		.i_cfg_op   (i_cfg_op),
		.i_cfg_dest (i_cfg_dest),
		.i_cfg_src  (i_cfg_src),
		.o_cmd      (route_cmd)
	);

	xbar_core core
	(
		.CLK      (CLK),
		.i_arst_n (i_arst_n),
		.i_en     (i_en),
		.i_valid  (i_valid),
		.i_data   (i_data),
		.i_cmd    (route_cmd),
		.o_valid  (o_valid),
		.o_data   (o_data)
	);

endmodule

`default_nettype wire

//--- sim/xbar_chk.sv
`timescale 1ns/1ns
`default_nettype none

`include "xbar_macros.svh"

// bound checker on the fabric ports, with its own shadow route table
module xbar_chk
(
	input  logic                                         CLK,
	input  logic                                         i_arst_n,
	input  logic                                         i_en,
	input  xbar_lane_pkg::lane_valid_t                   i_valid,
	input  xbar_lane_pkg::lane_data_t [`XBAR_PORTS-1:0]  i_data,
	input  xbar_route_pkg::cfg_op_e                      i_cfg_op,
	input  xbar_route_pkg::port_idx_t                    i_cfg_dest,
	input  xbar_route_pkg::port_idx_t                    i_cfg_src,
	input  xbar_lane_pkg::lane_valid_t                   o_valid,
	input  xbar_lane_pkg::lane_data_t [`XBAR_PORTS-1:0]  o_data
);
	import xbar_lane_pkg::*;
	import xbar_route_pkg::*;

	localparam int LAT = `XBAR_LATENCY;

	port_idx_t                     sh_src [`XBAR_PORTS];
	logic [`XBAR_PORTS-1:0]        sh_routed;
	lane_valid_t                   exp_valid; // what each dest should get from this edge
	lane_data_t [`XBAR_PORTS-1:0]  exp_data;
	lane_valid_t                   pipe_valid [LAT];
	lane_data_t [`XBAR_PORTS-1:0]  pipe_data  [LAT];
	logic [LAT-1:0]                en_hist;   // i_en at the last LAT edges
	logic                          data_ok;
	int unsigned                   fails = 0; // watched by the testbench

	always_ff @(posedge CLK or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			sh_routed <= '0;
			for (int d = 0; d < `XBAR_PORTS; d++)
				sh_src[d] <= '0;
		end
		else
		begin
			case (i_cfg_op)
				CFG_SET:
				begin
					sh_src[i_cfg_dest]    <= i_cfg_src;
					sh_routed[i_cfg_dest] <= 1'b1;
				end
				CFG_CLEAR:     sh_routed[i_cfg_dest] <= 1'b0;
				CFG_CLEAR_ALL: sh_routed <= '0;
				default:       ;
			endcase
		end
	end

	always_comb
	begin
		for (int d = 0; d < `XBAR_PORTS; d++)
		begin
			exp_valid[d] = sh_routed[d] & i_valid[sh_src[d]];
			exp_data[d]  = i_data[sh_src[d]];
		end
	end

	// expected words in flight, moving only on enabled edges
	always_ff @(posedge CLK or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			en_hist <= '0;
			for (int k = 0; k < LAT; k++)
			begin
				pipe_valid[k] <= '0;
				pipe_data[k]  <= '0;
			end
		end
		else
		begin
			en_hist <= {en_hist[LAT-2:0], i_en};
			if (i_en)
			begin
				pipe_valid[0] <= exp_valid;
				pipe_data[0]  <= exp_data;
				for (int k = 1; k < LAT; k++)
				begin
					pipe_valid[k] <= pipe_valid[k-1];
					pipe_data[k]  <= pipe_data[k-1];
				end
			end
		end
	end

	always_comb
	begin
		data_ok = 1'b1;
		for (int d = 0; d < `XBAR_PORTS; d++)
			if (pipe_valid[LAT-1][d] && o_data[d] != pipe_data[LAT-1][d])
				data_ok = 1'b0;
	end

	a_reset_quiet: assert property (@(posedge CLK) !i_arst_n |-> o_valid == '0)
		else begin fails++; $error("ERROR %0t: o_valid set during reset", $time); end

	a_valid_match: assert property (@(posedge CLK) disable iff (!i_arst_n)
		o_valid == pipe_valid[LAT-1])
		else begin fails++; $error("ERROR %0t: o_valid %h, expected %h", $time, o_valid,
			pipe_valid[LAT-1]); end

	a_data_match: assert property (@(posedge CLK) disable iff (!i_arst_n) data_ok)
		else begin fails++; $error("ERROR %0t: o_data differs on a valid lane", $time); end

	// straight run of enabled cycles, six back
	a_latency: assert property (@(posedge CLK) disable iff (!i_arst_n)
		(&en_hist) |-> o_valid == $past(exp_valid, LAT))
		else begin fails++; $error("ERROR %0t: o_valid not the source valid %0d cycles back",
			$time, LAT); end

	a_stall_hold: assert property (@(posedge CLK) disable iff (!i_arst_n)
		!$past(i_en) |-> (o_valid == $past(o_valid) && o_data == $past(o_data)))
		else begin fails++; $error("ERROR %0t: outputs moved while stalled", $time); end

endmodule

bind xbar_top xbar_chk chk0
(
	.CLK        (CLK),
	.i_arst_n   (i_arst_n),
	.i_en       (i_en),
	.i_valid    (i_valid),
	.i_data     (i_data),
	.i_cfg_op   (i_cfg_op),
	.i_cfg_dest (i_cfg_dest),
	.i_cfg_src  (i_cfg_src),
	.o_valid    (o_valid),
	.o_data     (o_data)
);

`default_nettype wire

//--- sim/xbar_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "xbar_macros.svh"

module xbar_tb;
	import xbar_lane_pkg::*;
	import xbar_route_pkg::*;

	localparam int WAIT_MAX = 40; // cycles before a wait gives up

	logic                          CLK = 1'b0;
	logic                          i_arst_n;
	logic                          i_en;
	lane_valid_t                   i_valid;
	lane_data_t [`XBAR_PORTS-1:0]  i_data;
	cfg_op_e                       i_cfg_op;
	port_idx_t                     i_cfg_dest;
	port_idx_t                     i_cfg_src;
	lane_valid_t                   o_valid;
	lane_data_t [`XBAR_PORTS-1:0]  o_data;

	integer     seed = 32'h5c33;
	port_idx_t  perm [`XBAR_PORTS];

	xbar_top dut0
	(
		.CLK        (CLK),
		.i_arst_n   (i_arst_n),
		.i_en       (i_en),
		.i_valid    (i_valid),
		.i_data     (i_data),
		.i_cfg_op   (i_cfg_op),
		.i_cfg_dest (i_cfg_dest),
		.i_cfg_src  (i_cfg_src),
		.o_valid    (o_valid),
		.o_data     (o_data)
	);

	// clock starts low, first edge is a rise at 2 ns
	initial
	begin
		forever #2 CLK = ~CLK;
	end

	// first assertion failure in the checker ends the run
	always @(negedge CLK)
	begin
		if (dut0.chk0.fails != 0)
		begin
			$display("TEST FAILED");
			$fatal(1, "an assertion in the bound checker failed");
		end
	end

	task automatic cfg(input cfg_op_e op, input int dest, input int src);
		@(negedge CLK);
		i_cfg_op   = op;
		i_cfg_dest = port_idx_t'(dest);
		i_cfg_src  = port_idx_t'(src);
		@(negedge CLK);
		i_cfg_op = CFG_NOP;
	endtask

	// random words on every lane for n cycles, under a valid mask
	task automatic send_words(input int n, input lane_valid_t mask);
		for (int c = 0; c < n; c++)
		begin
			@(negedge CLK);
			i_valid = mask;
			for (int s = 0; s < `XBAR_PORTS; s++)
				i_data[s] = $random(seed);
		end
		@(negedge CLK);
		i_valid = '0;
	endtask

	task automatic wait_lane(input int d, input logic level);
		int cycles;
		cycles = 0;
		while (o_valid[d] !== level)
		begin
			@(negedge CLK);
			cycles++;
			if (cycles > WAIT_MAX)
			begin
				$display("TEST FAILED");
				$fatal(1, "timeout: destination %0d valid never went to %0b", d, level);
			end
		end
	endtask

	task automatic wait_all_idle();
		int cycles;
		cycles = 0;
		while (o_valid !== '0)
		begin
			@(negedge CLK);
			cycles++;
			if (cycles > WAIT_MAX)
			begin
				$display("TEST FAILED");
				$fatal(1, "timeout: destinations still valid after clearing all routes");
			end
		end
	endtask

	initial
	begin
		int j;
		port_idx_t tmp;
		i_arst_n   = 1'b0;
		i_en       = 1'b1;
		i_valid    = '0;
		i_data     = '0;
		i_cfg_op   = CFG_NOP;
		i_cfg_dest = '0;
		i_cfg_src  = '0;
		repeat (5) @(negedge CLK);
		i_arst_n = 1'b1;

		send_words(3, '1); // nothing routed yet
		// unicast through a shuffled source order
		for (int i = 0; i < `XBAR_PORTS; i++)
			perm[i] = port_idx_t'(i);
		for (int i = `XBAR_PORTS-1; i > 0; i--)
		begin
			j = $unsigned($random(seed)) % (i+1);
			tmp = perm[i];
			perm[i] = perm[j];
			perm[j] = tmp;
		end
		for (int d = 0; d < `XBAR_PORTS; d++)
			cfg(CFG_SET, d, perm[d]);
		send_words(4, '1);
		wait_lane(0, 1'b1);

		// broadcast of one source
		cfg(CFG_SET, 1, 2);
		cfg(CFG_SET, 3, 2);
		cfg(CFG_SET, 5, 2);
		send_words(4, '1);
		wait_lane(5, 1'b1);

		send_words(6, lane_valid_t'($random(seed))); // some sources invalid

		// stall in the middle of a stream
		send_words(3, '1);
		@(negedge CLK);
		i_en = 1'b0;
		send_words(3, '1); // not sampled
		@(negedge CLK);
		i_en = 1'b1;
		wait_lane(1, 1'b1);
		send_words(8, '1);

		cfg(CFG_CLEAR, 3, 0);
		send_words(10, '1);
		wait_lane(3, 1'b0);
		cfg(CFG_CLEAR_ALL, 0, 0);
		send_words(10, '1);
		wait_all_idle();
		repeat (8) @(negedge CLK);

		if (dut0.chk0.fails == 0)
		begin
			$display("TEST OK");
			$finish;
		end
		else
		begin
			$display("TEST FAILED");
			$fatal(1, "assertion failures were counted");
		end
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/xbar_lane_pkg.sv
design/xbar_route_pkg.sv
design/xbar_fanout_tree.sv
design/xbar_mux_tree.sv
design/xbar_core.sv
design/xbar_route_table.sv
design/xbar_top.sv
sim/xbar_chk.sv
sim/xbar_tb.sv

//--- run.sh
#!/bin/sh
# build and run the crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module xbar_tb -o xbar_sim

status=0
./obj_dir/xbar_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ]; then
	exit "$status"
fi
grep -q "TEST OK" sim.log
